// ==== cellbuf_config.svh ====
`ifndef CELLBUF_CONFIG_SVH
`define CELLBUF_CONFIG_SVH

// Pixel and cell geometry
`define CB_PIXEL_W          8
`define CB_CELL_PIX         8

// Cells covered by one incoming pixel group
`define CB_GROUP_CELLS      4

// Frame size in cells
`define CB_LINE_CELLS       8
`define CB_FRAME_CELL_ROWS  4

// Groups needed for one full pixel row of the line
`define CB_GROUPS_PER_ROW   (`CB_LINE_CELLS / `CB_GROUP_CELLS)

`endif

// ==== cellbuf_pkg.sv ====
`include "cellbuf_config.svh"

package cellbuf_pkg;

    // Field widths of the write position and the cell index
    localparam int GROUP_W     = $clog2(`CB_GROUPS_PER_ROW);
    localparam int CROW_W      = $clog2(`CB_CELL_PIX);
    localparam int CELL_ROW_W  = $clog2(`CB_FRAME_CELL_ROWS);
    localparam int CELL_ADDR_W = $clog2(`CB_LINE_CELLS);

    // Pixel k of a cell row sits at index k
    typedef logic [`CB_CELL_PIX-1:0][`CB_PIXEL_W-1:0] pixel_row_t;

    // Lane j belongs to cell group*4 + j
    typedef struct packed {
        pixel_row_t [`CB_GROUP_CELLS-1:0] lane;
    } pgroup_t;

    typedef struct packed {
        logic [GROUP_W-1:0]    group;
        logic [CROW_W-1:0]     crow;
        logic [CELL_ROW_W-1:0] cell_row;
    } cell_pos_t;

    // Interior row 0 first, then the halo rows
    typedef struct packed {
        pixel_row_t [0:`CB_CELL_PIX-1] interior;
        pixel_row_t                    top;
        pixel_row_t                    bottom;
    } cell_view_t;

    typedef logic [CELL_ADDR_W-1:0] cell_addr_t;

endpackage

// ==== cellbuf_tb.sv ====
`timescale 1ns/10ps
`include "cellbuf_config.svh"

module cellbuf_tb;
    import cellbuf_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int TBL_MAX      = 128;

    typedef struct packed {
        logic       is_store;
        logic       check;
        cell_addr_t addr;
        pgroup_t    data;
    } tb_entry_t;

    logic       clk;
    logic       arst_n_i;
    pgroup_t    pgroup_i;
    logic       pgroup_wr_i;
    cell_addr_t cell_addr_i;
    logic       cell_store_i;
    cell_view_t cell_o;

    tb_entry_t  tbl [TBL_MAX];
    int         tbl_len;
    int         timeout_limit;
    int         cycles;
    int         checks;
    int         errors;
    logic [31:0] rand_state;

    // Reference model of the line buffer and its write position
    pixel_row_t m_int [`CB_LINE_CELLS][`CB_CELL_PIX];
    pixel_row_t m_top [`CB_LINE_CELLS];
    pixel_row_t m_bot [`CB_LINE_CELLS];
    int         m_group;
    int         m_crow;
    int         m_cell_row;

    tb_clock_gen #(.PERIOD_NS(100.0)) u_clk (.clk_o(clk));

    cellbuf_top dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pgroup_i     (pgroup_i),
        .pgroup_wr_i  (pgroup_wr_i),
        .cell_addr_i  (cell_addr_i),
        .cell_store_i (cell_store_i),
        .cell_o       (cell_o)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic push_writes(input int n);
        pgroup_t g;
        for (int k = 0; k < n; k++) begin
            for (int w = 0; w < $bits(pgroup_t) / 32; w++) begin
                rand_state = lcg_step(rand_state);
                g[w*32 +: 32] = rand_state;
            end
            tbl[tbl_len] = '{is_store: 1'b0, check: 1'b0, addr: '0, data: g};
            tbl_len++;
        end
    endtask

    // One store per cell of the line
    task automatic push_store_sweep(input logic check);
        for (int c = 0; c < `CB_LINE_CELLS; c++) begin
            tbl[tbl_len] = '{is_store: 1'b1, check: check, addr: cell_addr_t'(c), data: '0};
            tbl_len++;
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic model_write(input pgroup_t g);
        int c;
        for (int j = 0; j < `CB_GROUP_CELLS; j++) begin
            c = m_group * `CB_GROUP_CELLS + j;
            if (m_crow != 0) begin
                m_int[c][m_crow] = g.lane[j];
            end else begin
                m_bot[c] = g.lane[j];
                if (m_cell_row == 0) begin
                    m_int[c][0] = g.lane[j];
                end
            end
        end
        m_group++;
        if (m_group == `CB_GROUPS_PER_ROW) begin
            m_group = 0;
            m_crow++;
            if (m_crow == `CB_CELL_PIX) begin
                m_crow = 0;
                m_cell_row = (m_cell_row + 1) % `CB_FRAME_CELL_ROWS;
            end
        end
    endtask

    task automatic model_store(input cell_addr_t a);
        m_top[a]    = m_int[a][`CB_CELL_PIX-1];
        m_int[a][0] = m_bot[a];
    endtask

    task automatic check_cell(input cell_addr_t a);
        for (int r = 0; r < `CB_CELL_PIX; r++) begin
            compare_value($sformatf("cell_o.interior[%0d] cell %0d", r, a),
                          cell_o.interior[r], m_int[a][r]);
        end
        compare_value($sformatf("cell_o.top cell %0d", a), cell_o.top, m_top[a]);
        compare_value($sformatf("cell_o.bottom cell %0d", a), cell_o.bottom, m_bot[a]);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        arst_n_i     = 1'b0;
        pgroup_i     = '0;
        pgroup_wr_i  = 1'b0;
        cell_addr_i  = '0;
        cell_store_i = 1'b0;
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        tbl_len      = 0;
        rand_state   = 32'h770d;
        m_group      = 0;
        m_crow       = 0;
        m_cell_row   = 0;
        for (int c = 0; c < `CB_LINE_CELLS; c++) begin
            m_top[c] = '0;
            m_bot[c] = '0;
            for (int r = 0; r < `CB_CELL_PIX; r++) begin
                m_int[c][r] = '0;
            end
        end

        // Reset state, cell row 0, crow 0 of row 1, rest of row 1, rows 2 and 3, wrap
        push_store_sweep(1'b1);
        push_writes(16);
        push_store_sweep(1'b1);
        push_writes(2);
        push_store_sweep(1'b1);
        push_writes(14);
        push_store_sweep(1'b1);
        push_writes(16);
        push_store_sweep(1'b0);
        push_writes(16);
        push_store_sweep(1'b0);
        push_writes(2);
        push_store_sweep(1'b1);
        timeout_limit = tbl_len + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;

        for (int i = 0; i < tbl_len; i++) begin
            @(posedge clk);
            pgroup_i     <= tbl[i].data;
            pgroup_wr_i  <= !tbl[i].is_store;
            cell_store_i <= tbl[i].is_store;
            cell_addr_i  <= tbl[i].addr;
            @(negedge clk);
            if (tbl[i].is_store) begin
                if (tbl[i].check) begin
                    check_cell(tbl[i].addr);
                end
                model_store(tbl[i].addr);
            end else begin
                model_write(tbl[i].data);
            end
        end
        @(posedge clk);
        pgroup_wr_i  <= 1'b0;
        cell_store_i <= 1'b0;
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== cellbuf_top.sv ====
`timescale 1ns/10ps
`include "cellbuf_config.svh"

module cellbuf_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  cellbuf_pkg::pgroup_t    pgroup_i,
    input  logic                    pgroup_wr_i,
    input  cellbuf_pkg::cell_addr_t cell_addr_i,
    input  logic                    cell_store_i,
    output cellbuf_pkg::cell_view_t cell_o
);
    import cellbuf_pkg::*;

    cell_pos_t                     pos;
    pixel_row_t [0:`CB_CELL_PIX-1] interior;
    pixel_row_t                    top;
    pixel_row_t                    bottom;

    pixel_pos_counter u_pos_counter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pgroup_wr_i (pgroup_wr_i),
        .pos_o       (pos)
    );

    interior_pixel_store u_interior (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pgroup_i     (pgroup_i),
        .pgroup_wr_i  (pgroup_wr_i),
        .pos_i        (pos),
        .cell_addr_i  (cell_addr_i),
        .cell_store_i (cell_store_i),
        .bottom_i     (bottom),
        .interior_o   (interior)
    );

    halo_pixel_store u_halo (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pgroup_i     (pgroup_i),
        .pgroup_wr_i  (pgroup_wr_i),
        .pos_i        (pos),
        .cell_addr_i  (cell_addr_i),
        .cell_store_i (cell_store_i),
        .interior_i   (interior),
        .top_o        (top),
        .bottom_o     (bottom)
    );

    // Addressed cell with both halos, no register in the path
    assign cell_o.interior = interior;
    assign cell_o.top      = top;
    assign cell_o.bottom   = bottom;

endmodule

// ==== compile.f ====
+incdir+.
cellbuf_pkg.sv
pixel_pos_counter.sv
interior_pixel_store.sv
halo_pixel_store.sv
cellbuf_top.sv
tb_clock_gen.sv
cellbuf_tb.sv

// ==== halo_pixel_store.sv ====
`timescale 1ns/10ps
`include "cellbuf_config.svh"

module halo_pixel_store (
    input  logic                                         clk,
    input  logic                                         arst_n_i,
    input  cellbuf_pkg::pgroup_t                         pgroup_i,
    input  logic                                         pgroup_wr_i,
    input  cellbuf_pkg::cell_pos_t                       pos_i,
    input  cellbuf_pkg::cell_addr_t                      cell_addr_i,
    input  logic                                         cell_store_i,
    input  cellbuf_pkg::pixel_row_t [0:`CB_CELL_PIX-1]   interior_i,
    output cellbuf_pkg::pixel_row_t                      top_o,
    output cellbuf_pkg::pixel_row_t                      bottom_o
);
    import cellbuf_pkg::*;

    // One halo row above and one below each cell
    pixel_row_t top_q [`CB_LINE_CELLS];
    pixel_row_t bot_q [`CB_LINE_CELLS];

    logic capture;

    // Pixel row 0 of a cell belongs below the cell row above
    assign capture = pgroup_wr_i && (pos_i.crow == '0);

    for (genvar c = 0; c < `CB_LINE_CELLS; c++) begin : g_cell
        localparam int                  LANE = c % `CB_GROUP_CELLS;
        localparam logic [GROUP_W-1:0]  GRP  = GROUP_W'(c / `CB_GROUP_CELLS);

        logic cap_hit;
        logic st_hit;

        assign cap_hit = capture && (pos_i.group == GRP);
        assign st_hit  = cell_store_i && (cell_addr_i == CELL_ADDR_W'(c));

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                bot_q[c] <= '0;
            end else if (cap_hit) begin
                bot_q[c] <= pgroup_i.lane[LANE];
            end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                top_q[c] <= '0;
            end else if (st_hit) begin
                // Last interior row turns into the top halo of the next cell row
                top_q[c] <= interior_i[`CB_CELL_PIX-1];
            end
        end
    end

    assign top_o    = top_q[cell_addr_i];
    assign bottom_o = bot_q[cell_addr_i];

endmodule

// ==== interior_pixel_store.sv ====
`timescale 1ns/10ps
`include "cellbuf_config.svh"

module interior_pixel_store (
    input  logic                                         clk,
    input  logic                                         arst_n_i,
    input  cellbuf_pkg::pgroup_t                         pgroup_i,
    input  logic                                         pgroup_wr_i,
    input  cellbuf_pkg::cell_pos_t                       pos_i,
    input  cellbuf_pkg::cell_addr_t                      cell_addr_i,
    input  logic                                         cell_store_i,
    input  cellbuf_pkg::pixel_row_t                      bottom_i,
    output cellbuf_pkg::pixel_row_t [0:`CB_CELL_PIX-1]   interior_o
);
    import cellbuf_pkg::*;

    // Interior rows of every cell in the line
    pixel_row_t [0:`CB_CELL_PIX-1] ipix_q [`CB_LINE_CELLS];

    logic crow_zero;
    logic frame_top;

    assign crow_zero = (pos_i.crow == '0);
    assign frame_top = (pos_i.cell_row == '0);

    for (genvar c = 0; c < `CB_LINE_CELLS; c++) begin : g_cell
        localparam int                  LANE = c % `CB_GROUP_CELLS;
        localparam logic [GROUP_W-1:0]  GRP  = GROUP_W'(c / `CB_GROUP_CELLS);

        logic wr_hit;
        logic st_hit;

        assign wr_hit = pgroup_wr_i && (pos_i.group == GRP);
        assign st_hit = cell_store_i && (cell_addr_i == CELL_ADDR_W'(c));

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                ipix_q[c] <= '0;
            end else if (wr_hit) begin
                if (!crow_zero) begin
                    ipix_q[c][pos_i.crow] <= pgroup_i.lane[LANE];
                end else if (frame_top) begin
                    // No cell above in frame row 0, so row 0 comes straight in
                    ipix_q[c][0] <= pgroup_i.lane[LANE];
                end
            end else if (st_hit) begin
                // Captured bottom halo becomes row 0 of the next cell row
                ipix_q[c][0] <= bottom_i;
            end
        end
    end

    assign interior_o = ipix_q[cell_addr_i];

    // Both strobes in one cycle would race on interior row 0
    wr_store_excl_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(pgroup_wr_i && cell_store_i)
    ) else begin
        $error("pgroup_wr_i and cell_store_i high in the same cycle");
    end

endmodule

// ==== pixel_pos_counter.sv ====
`timescale 1ns/10ps
`include "cellbuf_config.svh"

module pixel_pos_counter (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   pgroup_wr_i,
    output cellbuf_pkg::cell_pos_t pos_o
);
    import cellbuf_pkg::*;

    localparam logic [GROUP_W-1:0]    LAST_GROUP    = GROUP_W'(`CB_GROUPS_PER_ROW - 1);
    localparam logic [CROW_W-1:0]     LAST_CROW     = CROW_W'(`CB_CELL_PIX - 1);
    localparam logic [CELL_ROW_W-1:0] LAST_CELL_ROW = CELL_ROW_W'(`CB_FRAME_CELL_ROWS - 1);

    cell_pos_t pos_q;
    cell_pos_t pos_d;

    // Group carries into crow, crow carries into cell row
    always_comb begin
        pos_d = pos_q;
        if (pos_q.group == LAST_GROUP) begin
            pos_d.group = '0;
            if (pos_q.crow == LAST_CROW) begin
                pos_d.crow = '0;
                if (pos_q.cell_row == LAST_CELL_ROW) begin
                    // End of frame, back to cell row 0
                    pos_d.cell_row = '0;
                end else begin
                    pos_d.cell_row = pos_q.cell_row + 1'b1;
                end
            end else begin
                pos_d.crow = pos_q.crow + 1'b1;
            end
        end else begin
            pos_d.group = pos_q.group + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pos_q <= '0;
        end else if (pgroup_wr_i) begin
            pos_q <= pos_d;
        end
    end

    assign pos_o = pos_q;

    // An unknown strobe would leave the position undefined
    wr_known_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(pgroup_wr_i)
    ) else begin
        $error("pgroup_wr_i is unknown");
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk_o
);

    // Free running clock, low for the first half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule
